// File: all.f
hdl/bus_pkg.sv
hdl/core_pkg.sv
hdl/axi_lite_if.sv
hdl/bus_arbiter.sv
hdl/sram_slave.sv
hdl/clint_timer.sv
hdl/mem_subsys_top.sv
verif/tb_clock_gen.sv
verif/mem_subsys_tb.sv

// File: hdl/axi_lite_if.sv
`timescale 1ns/100ps

interface axi_lite_if ();
  import bus_pkg::*;

  // write address channel
  logic [BUS_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  // write data channel
  logic [BUS_DATA_W-1:0] wdata;
  logic [BUS_STRB_W-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  // write response channel
  axi_resp_e             bresp;
  logic                  bvalid;
  logic                  bready;
  // read address channel
  logic [BUS_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  // read data channel
  logic [BUS_DATA_W-1:0] rdata;
  axi_resp_e             rresp;
  logic                  rvalid;
  logic                  rready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

// File: hdl/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter #(
  parameter int unsigned SRAM_WORDS = 256
) (
  input  logic                             clk,
  input  logic                             rst,
  // instruction fetch, always a word read
  input  logic                             fetch_req_valid_i,
  input  logic [bus_pkg::BUS_ADDR_W-1:0]   fetch_addr_i,
  output logic                             fetch_req_ready_o,
  output logic                             fetch_rsp_valid_o,
  output logic [core_pkg::CORE_DATA_W-1:0] fetch_rdata_o,
  output logic                             fetch_rsp_err_o,
  // load/store unit
  input  logic                             lsu_req_valid_i,
  input  logic                             lsu_we_i,
  input  core_pkg::mem_size_e              lsu_size_i,
  input  logic [bus_pkg::BUS_ADDR_W-1:0]   lsu_addr_i,
  input  logic [core_pkg::CORE_DATA_W-1:0] lsu_wdata_i,
  output logic                             lsu_req_ready_o,
  output logic                             lsu_rsp_valid_o,
  output logic [core_pkg::CORE_DATA_W-1:0] lsu_rdata_o,
  output logic                             lsu_rsp_err_o,
  // slave buses
  axi_lite_if.master                       mem_bus,
  axi_lite_if.master                       tmr_bus
);
  import bus_pkg::*;
  import core_pkg::*;

  // window ends, exclusive
  localparam logic [BUS_ADDR_W-1:0] SRAM_END  = SRAM_BASE + BUS_ADDR_W'(SRAM_WORDS * 8);
  localparam logic [BUS_ADDR_W-1:0] CLINT_END = CLINT_BASE + CLINT_SPAN;

  arb_state_e             state_q;
  logic                   aw_done_q;
  logic                   w_done_q;
  logic                   owner_lsu_q;
  logic                   we_q;
  logic                   tgt_clint_q;
  mem_size_e              size_q;
  logic [BUS_ADDR_W-1:0]  addr_q;
  logic [CORE_DATA_W-1:0] wdata_q;
  logic                   rsp_err_q;
  logic [CORE_DATA_W-1:0] rsp_data_q;

  logic                   accept;
  logic [BUS_ADDR_W-1:0]  req_addr;
  mem_size_e              req_size;
  logic                   in_sram;
  logic                   in_clint;
  logic                   misaligned;
  logic                   req_err;
  logic [4:0]             lane_sh;
  logic [CORE_DATA_W-1:0] st_data;
  logic [BUS_STRB_W-1:0]  strb;
  logic                   aw_req;
  logic                   w_req;
  logic                   ar_req;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   ar_hs;
  logic                   addr_done;
  logic                   resp_in;
  axi_resp_e              resp_code;
  logic [BUS_DATA_W-1:0]  sel_rdata;
  logic [CORE_DATA_W-1:0] ld_half;
  logic [CORE_DATA_W-1:0] ld_data;

  // byte lanes touched by a size, before the address shift
  function automatic logic [3:0] size_strb(mem_size_e sz);
    case (sz)
      SZ_BYTE: return 4'b0001;
      SZ_HALF: return 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  // zero-extension mask for loads
  function automatic logic [CORE_DATA_W-1:0] size_mask(mem_size_e sz);
    case (sz)
      SZ_BYTE: return 32'h0000_00FF;
      SZ_HALF: return 32'h0000_FFFF;
      default: return 32'hFFFF_FFFF;
    endcase
  endfunction

  // fixed priority, lsu ahead of fetch
  assign lsu_req_ready_o   = (state_q == IDLE) && lsu_req_valid_i;
  assign fetch_req_ready_o = (state_q == IDLE) && fetch_req_valid_i && !lsu_req_valid_i;
  assign accept            = lsu_req_ready_o || fetch_req_ready_o;
  assign req_addr          = lsu_req_valid_i ? lsu_addr_i : fetch_addr_i;
  assign req_size          = lsu_req_valid_i ? lsu_size_i : SZ_WORD;

  // address decode
  assign in_sram  = (req_addr >= SRAM_BASE) && (req_addr < SRAM_END);
  assign in_clint = (req_addr >= CLINT_BASE) && (req_addr < CLINT_END);

  always_comb
  begin
    case (req_size)
      SZ_BYTE: misaligned = 1'b0;
      SZ_HALF: misaligned = req_addr[0];
      SZ_WORD: misaligned = |req_addr[1:0];
      default: misaligned = 1'b1;
    endcase
  end

  // answered locally, never reaches a slave
  assign req_err = misaligned || !(in_sram || in_clint);

  // store lanes, same 32 bits on both halves
  assign lane_sh = {addr_q[1:0], 3'b000};
  assign st_data = wdata_q << lane_sh;
  assign strb    = BUS_STRB_W'(size_strb(size_q)) << addr_q[2:0];

  // channel requests while in ADDR
  assign aw_req = (state_q == ADDR) && we_q && !aw_done_q;
  assign w_req  = (state_q == ADDR) && we_q && !w_done_q;
  assign ar_req = (state_q == ADDR) && !we_q;

  // payload is common, only the valids are steered
  assign mem_bus.awaddr  = addr_q;
  assign mem_bus.awvalid = aw_req && !tgt_clint_q;
  assign mem_bus.wdata   = {st_data, st_data};
  assign mem_bus.wstrb   = strb;
  assign mem_bus.wvalid  = w_req && !tgt_clint_q;
  assign mem_bus.bready  = (state_q == WAIT_RESP);
  assign mem_bus.araddr  = addr_q;
  assign mem_bus.arvalid = ar_req && !tgt_clint_q;
  assign mem_bus.rready  = (state_q == WAIT_RESP);

  assign tmr_bus.awaddr  = addr_q;
  assign tmr_bus.awvalid = aw_req && tgt_clint_q;
  assign tmr_bus.wdata   = {st_data, st_data};
  assign tmr_bus.wstrb   = strb;
  assign tmr_bus.wvalid  = w_req && tgt_clint_q;
  assign tmr_bus.bready  = (state_q == WAIT_RESP);
  assign tmr_bus.araddr  = addr_q;
  assign tmr_bus.arvalid = ar_req && tgt_clint_q;
  assign tmr_bus.rready  = (state_q == WAIT_RESP);

  // handshakes on the selected slave
  assign aw_hs = aw_req && (tgt_clint_q ? tmr_bus.awready : mem_bus.awready);
  assign w_hs  = w_req && (tgt_clint_q ? tmr_bus.wready : mem_bus.wready);
  assign ar_hs = ar_req && (tgt_clint_q ? tmr_bus.arready : mem_bus.arready);

  // aw and w may complete in different cycles
  assign addr_done = we_q ? ((aw_done_q || aw_hs) && (w_done_q || w_hs)) : ar_hs;

  assign resp_in = (state_q == WAIT_RESP) &&
                   (we_q ? (tgt_clint_q ? tmr_bus.bvalid : mem_bus.bvalid)
                         : (tgt_clint_q ? tmr_bus.rvalid : mem_bus.rvalid));
  assign resp_code = we_q ? (tgt_clint_q ? tmr_bus.bresp : mem_bus.bresp)
                          : (tgt_clint_q ? tmr_bus.rresp : mem_bus.rresp);
  assign sel_rdata = tgt_clint_q ? tmr_bus.rdata : mem_bus.rdata;

  // bit 2 picks the half, then shift down and zero-extend
  assign ld_half = addr_q[2] ? sel_rdata[BUS_DATA_W-1:CORE_DATA_W] : sel_rdata[CORE_DATA_W-1:0];
  assign ld_data = (ld_half >> lane_sh) & size_mask(size_q);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (accept)
          begin
            state_q <= req_err ? RESP : ADDR;
          end
        end
        ADDR:
        begin
          if (addr_done)
          begin
            state_q   <= WAIT_RESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
          else
          begin
            aw_done_q <= aw_done_q || aw_hs;
            w_done_q  <= w_done_q || w_hs;
          end
        end
        WAIT_RESP:
        begin
          if (resp_in)
          begin
            state_q <= RESP;
          end
        end
        default:
        begin
          // RESP lasts one cycle
          state_q <= IDLE;
        end
      endcase
    end
  end

  // granted request and response payload
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      owner_lsu_q <= lsu_req_valid_i;
      we_q        <= lsu_req_valid_i && lsu_we_i;
      size_q      <= req_size;
      addr_q      <= req_addr;
      wdata_q     <= lsu_wdata_i;
      tgt_clint_q <= in_clint;
      rsp_err_q   <= req_err;
      rsp_data_q  <= '0;
    end
    else if (resp_in)
    begin
      rsp_err_q  <= resp_code inside {SLVERR, DECERR};
      // writes and failed reads return zero
      rsp_data_q <= (we_q || resp_code != OKAY) ? '0 : ld_data;
    end
  end

  assign lsu_rsp_valid_o   = (state_q == RESP) && owner_lsu_q;
  assign fetch_rsp_valid_o = (state_q == RESP) && !owner_lsu_q;
  assign lsu_rdata_o       = rsp_data_q;
  assign fetch_rdata_o     = rsp_data_q;
  assign lsu_rsp_err_o     = rsp_err_q;
  assign fetch_rsp_err_o   = rsp_err_q;

  // one transaction at a time on each bus
  a_mem_one_dir: assert property (@(posedge clk) disable iff (rst)
    !(mem_bus.awvalid && mem_bus.arvalid));
  a_tmr_one_dir: assert property (@(posedge clk) disable iff (rst)
    !(tmr_bus.awvalid && tmr_bus.arvalid));
  // a response goes to exactly one requester
  a_one_rsp: assert property (@(posedge clk) disable iff (rst)
    !(fetch_rsp_valid_o && lsu_rsp_valid_o));

endmodule

// File: hdl/bus_pkg.sv
package bus_pkg;

  // axi4-lite bus geometry
  localparam int unsigned BUS_DATA_W = 64;
  localparam int unsigned BUS_ADDR_W = 32;
  localparam int unsigned BUS_STRB_W = BUS_DATA_W / 8;

  // response codes as carried on bresp and rresp
  // exokay has no use without exclusive access
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // sram window base, its size follows the sram depth
  localparam logic [31:0] SRAM_BASE = 32'h8000_0000;

  // clint window
  localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [31:0] CLINT_SPAN = 32'h0001_0000;

  // clint register offsets within the window
  localparam logic [15:0] CLINT_MTIMECMP_OFS = 16'h4000;
  localparam logic [15:0] CLINT_MTIME_OFS    = 16'hBFF8;

endpackage

// File: hdl/clint_timer.sv
`timescale 1ns/100ps

module clint_timer (
  input  logic      clk,
  input  logic      rst,
  axi_lite_if.slave bus,
  output logic      timer_irq_o
);
  import bus_pkg::*;

  logic [BUS_DATA_W-1:0] mtime_q;
  logic [BUS_DATA_W-1:0] mtimecmp_q;
  logic [BUS_DATA_W-1:0] rdata_q;
  logic                  rvalid_q;
  logic                  bvalid_q;
  axi_resp_e             bresp_q;
  logic                  ar_hs;
  logic                  wr_hs;
  logic                  rd_cmp;
  logic                  rd_time;
  logic                  wr_cmp;
  logic                  wr_time;

  // 8-byte slots, matched above the byte offset
  assign rd_cmp  = bus.araddr[15:3] == CLINT_MTIMECMP_OFS[15:3];
  assign rd_time = bus.araddr[15:3] == CLINT_MTIME_OFS[15:3];
  assign wr_cmp  = bus.awaddr[15:3] == CLINT_MTIMECMP_OFS[15:3];
  assign wr_time = bus.awaddr[15:3] == CLINT_MTIME_OFS[15:3];

  // same handshake timing as the sram
  assign bus.arready = !rvalid_q;
  assign ar_hs       = bus.arvalid && bus.arready;
  assign bus.awready = bus.wvalid && !bvalid_q;
  assign bus.wready  = bus.awvalid && !bvalid_q;
  assign wr_hs       = bus.awvalid && bus.awready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
      rvalid_q    <= 1'b0;
      bvalid_q    <= 1'b0;
    end
    else
    begin
      // free running, software cannot write it
      mtime_q     <= mtime_q + 64'd1;
      timer_irq_o <= mtime_q >= mtimecmp_q;
      if (wr_hs && wr_cmp)
      begin
        for (int i = 0; i < BUS_STRB_W; i++)
        begin
          if (bus.wstrb[i])
          begin
            mtimecmp_q[8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
      end
      if (ar_hs)
      begin
        rvalid_q <= 1'b1;
      end
      else if (bus.rready)
      begin
        rvalid_q <= 1'b0;
      end
      if (wr_hs)
      begin
        bvalid_q <= 1'b1;
      end
      else if (bus.bready)
      begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // response payload
  always_ff @(posedge clk)
  begin
    if (ar_hs)
    begin
      // unmapped offsets read as zero
      rdata_q <= rd_cmp ? mtimecmp_q : (rd_time ? mtime_q : '0);
    end
    if (wr_hs)
    begin
      bresp_q <= wr_time ? SLVERR : OKAY;
    end
  end

  assign bus.rdata  = rdata_q;
  assign bus.rresp  = OKAY;
  assign bus.rvalid = rvalid_q;
  assign bus.bresp  = bresp_q;
  assign bus.bvalid = bvalid_q;

  // read data only after an accepted read address
  a_r_after_ar: assert property (@(posedge clk) disable iff (rst)
    $rose(bus.rvalid) |-> $past(bus.arvalid && bus.arready));

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

  // requester data path width
  localparam int unsigned CORE_DATA_W = 32;

  // access size from the load/store unit
  // 2'd3 is not a legal size
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } mem_size_e;

  // arbiter fsm
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    ADDR      = 2'd1,
    WAIT_RESP = 2'd2,
    RESP      = 2'd3
  } arb_state_e;

endpackage

// File: hdl/mem_subsys_top.sv
`timescale 1ns/100ps

module mem_subsys_top #(
  parameter int unsigned SRAM_WORDS = 256
) (
  input  logic                             clk,
  input  logic                             rst,
  // instruction fetch port
  input  logic                             fetch_req_valid_i,
  output logic                             fetch_req_ready_o,
  input  logic [bus_pkg::BUS_ADDR_W-1:0]   fetch_addr_i,
  output logic                             fetch_rsp_valid_o,
  output logic [core_pkg::CORE_DATA_W-1:0] fetch_rdata_o,
  output logic                             fetch_rsp_err_o,
  // load/store port
  input  logic                             lsu_req_valid_i,
  output logic                             lsu_req_ready_o,
  input  logic [bus_pkg::BUS_ADDR_W-1:0]   lsu_addr_i,
  input  logic                             lsu_we_i,
  input  core_pkg::mem_size_e              lsu_size_i,
  input  logic [core_pkg::CORE_DATA_W-1:0] lsu_wdata_i,
  output logic                             lsu_rsp_valid_o,
  output logic [core_pkg::CORE_DATA_W-1:0] lsu_rdata_o,
  output logic                             lsu_rsp_err_o,
  // machine timer interrupt
  output logic                             timer_irq_o
);

  // arbiter to sram
  axi_lite_if mem_bus ();
  // arbiter to clint
  axi_lite_if tmr_bus ();

  bus_arbiter #(
    .SRAM_WORDS(SRAM_WORDS)
  ) u_arbiter (
    .clk              (clk),
    .rst              (rst),
    .fetch_req_valid_i(fetch_req_valid_i),
    .fetch_addr_i     (fetch_addr_i),
    .fetch_req_ready_o(fetch_req_ready_o),
    .fetch_rsp_valid_o(fetch_rsp_valid_o),
    .fetch_rdata_o    (fetch_rdata_o),
    .fetch_rsp_err_o  (fetch_rsp_err_o),
    .lsu_req_valid_i  (lsu_req_valid_i),
    .lsu_we_i         (lsu_we_i),
    .lsu_size_i       (lsu_size_i),
    .lsu_addr_i       (lsu_addr_i),
    .lsu_wdata_i      (lsu_wdata_i),
    .lsu_req_ready_o  (lsu_req_ready_o),
    .lsu_rsp_valid_o  (lsu_rsp_valid_o),
    .lsu_rdata_o      (lsu_rdata_o),
    .lsu_rsp_err_o    (lsu_rsp_err_o),
    .mem_bus          (mem_bus),
    .tmr_bus          (tmr_bus)
  );

  sram_slave #(
    .SRAM_WORDS(SRAM_WORDS)
  ) u_sram (
    .clk(clk),
    .rst(rst),
    .bus(mem_bus)
  );

  clint_timer u_clint (
    .clk        (clk),
    .rst        (rst),
    .bus        (tmr_bus),
    .timer_irq_o(timer_irq_o)
  );

endmodule

// File: hdl/sram_slave.sv
`timescale 1ns/100ps

module sram_slave #(
  parameter int unsigned SRAM_WORDS = 256
) (
  input logic       clk,
  input logic       rst,
  axi_lite_if.slave bus
);
  import bus_pkg::*;

  localparam int unsigned IDX_W = $clog2(SRAM_WORDS);

  logic [BUS_DATA_W-1:0] mem [SRAM_WORDS];
  logic [BUS_DATA_W-1:0] rdata_q;
  logic                  rvalid_q;
  logic                  bvalid_q;
  logic [IDX_W-1:0]      rd_idx;
  logic [IDX_W-1:0]      wr_idx;
  logic                  ar_hs;
  logic                  wr_hs;

  // word index above the byte offset, wraps at the depth
  assign rd_idx = bus.araddr[IDX_W+2:3];
  assign wr_idx = bus.awaddr[IDX_W+2:3];

  // one read response in flight
  assign bus.arready = !rvalid_q;
  assign ar_hs       = bus.arvalid && bus.arready;

  // aw and w are taken in the same cycle
  assign bus.awready = bus.wvalid && !bvalid_q;
  assign bus.wready  = bus.awvalid && !bvalid_q;
  assign wr_hs       = bus.awvalid && bus.awready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end
    else
    begin
      // hold each response until the master takes it
      if (ar_hs)
      begin
        rvalid_q <= 1'b1;
      end
      else if (bus.rready)
      begin
        rvalid_q <= 1'b0;
      end
      if (wr_hs)
      begin
        bvalid_q <= 1'b1;
      end
      else if (bus.bready)
      begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // storage array and read data
  always_ff @(posedge clk)
  begin
    if (ar_hs)
    begin
      rdata_q <= mem[rd_idx];
    end
    if (wr_hs)
    begin
      for (int i = 0; i < BUS_STRB_W; i++)
      begin
        if (bus.wstrb[i])
        begin
          mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  assign bus.rdata  = rdata_q;
  assign bus.rresp  = OKAY;
  assign bus.rvalid = rvalid_q;
  assign bus.bresp  = OKAY;
  assign bus.bvalid = bvalid_q;

  // write response only follows an accepted address
  a_b_after_aw: assert property (@(posedge clk) disable iff (rst)
    $rose(bus.bvalid) |-> $past(bus.awvalid && bus.awready));

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it, exit status gives pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module mem_subsys_tb -o mem_subsys_sim &&
./obj_dir/mem_subsys_sim ||
{ echo "simulation did not pass"; exit 1; }

// File: verif/mem_subsys_tb.sv
`timescale 1ns/100ps

module mem_subsys_tb;
  import bus_pkg::*;
  import core_pkg::*;

  localparam int unsigned SEED       = 32'h823f_a786;
  // sram window at its default depth
  localparam int unsigned SRAM_BYTES = 256 * 8;
  // random traffic spans the whole prefilled window
  localparam int unsigned WIN_BYTES  = SRAM_BYTES;
  localparam int unsigned N_FILL     = WIN_BYTES / 4;
  localparam int unsigned N_LSU      = 300;
  localparam int unsigned N_FETCH    = 150;
  localparam int unsigned N_ERR      = 12;
  localparam int unsigned N_TMR      = 13;
  // each error case is followed by a check load
  localparam int unsigned N_TOTAL    = N_FILL + N_LSU + N_FETCH + 2 * N_ERR + N_TMR;
  localparam int unsigned MAX_CYCLES = N_TOTAL * 20 + 200;

  localparam logic [31:0] CMP_ADDR  = CLINT_BASE + {16'h0000, CLINT_MTIMECMP_OFS};
  localparam logic [31:0] TIME_ADDR = CLINT_BASE + {16'h0000, CLINT_MTIME_OFS};

  logic        clk;
  logic        rst;
  logic        fetch_req_valid_i;
  logic        fetch_req_ready_o;
  logic [31:0] fetch_addr_i;
  logic        fetch_rsp_valid_o;
  logic [31:0] fetch_rdata_o;
  logic        fetch_rsp_err_o;
  logic        lsu_req_valid_i;
  logic        lsu_req_ready_o;
  logic [31:0] lsu_addr_i;
  logic        lsu_we_i;
  mem_size_e   lsu_size_i;
  logic [31:0] lsu_wdata_i;
  logic        lsu_rsp_valid_o;
  logic [31:0] lsu_rdata_o;
  logic        lsu_rsp_err_o;
  logic        timer_irq_o;

  // byte model of the prefilled sram window
  logic [7:0]  model_mem [WIN_BYTES];
  int unsigned lsu_issued;
  int unsigned fetch_issued;
  int unsigned lsu_rsp_cnt;
  int unsigned fetch_rsp_cnt;

  tb_clock_gen u_clk_gen (
    .clk(clk),
    .rst(rst)
  );

  mem_subsys_top uut (
    .clk              (clk),
    .rst              (rst),
    .fetch_req_valid_i(fetch_req_valid_i),
    .fetch_req_ready_o(fetch_req_ready_o),
    .fetch_addr_i     (fetch_addr_i),
    .fetch_rsp_valid_o(fetch_rsp_valid_o),
    .fetch_rdata_o    (fetch_rdata_o),
    .fetch_rsp_err_o  (fetch_rsp_err_o),
    .lsu_req_valid_i  (lsu_req_valid_i),
    .lsu_req_ready_o  (lsu_req_ready_o),
    .lsu_addr_i       (lsu_addr_i),
    .lsu_we_i         (lsu_we_i),
    .lsu_size_i       (lsu_size_i),
    .lsu_wdata_i      (lsu_wdata_i),
    .lsu_rsp_valid_o  (lsu_rsp_valid_o),
    .lsu_rdata_o      (lsu_rdata_o),
    .lsu_rsp_err_o    (lsu_rsp_err_o),
    .timer_irq_o      (timer_irq_o)
  );

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp)
    begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      $display("tests failed");
      $fatal(1, "check %s did not match", name);
    end
  endtask

  // little endian bytes, zero-extended
  function automatic logic [31:0] expected_load(int unsigned off, mem_size_e sz);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < (1 << int'(sz)); k++)
    begin
      val[8*k +: 8] = model_mem[off + k];
    end
    return val;
  endfunction

  function automatic void apply_store(int unsigned off, mem_size_e sz, logic [31:0] data);
    for (int k = 0; k < (1 << int'(sz)); k++)
    begin
      model_mem[off + k] = data[8*k +: 8];
    end
  endfunction

  // one load/store request, checks the error flag
  task automatic issue_lsu(input string name, input logic we, input mem_size_e sz,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic exp_err, output logic [31:0] rdata);
    logic err;
    @(posedge clk);
    lsu_req_valid_i <= 1'b1;
    lsu_we_i        <= we;
    lsu_size_i      <= sz;
    lsu_addr_i      <= addr;
    lsu_wdata_i     <= wdata;
    lsu_issued++;
    // ready seen here means acceptance on the next edge
    do
      @(negedge clk);
    while (!lsu_req_ready_o);
    @(posedge clk);
    lsu_req_valid_i <= 1'b0;
    do
      @(negedge clk);
    while (!lsu_rsp_valid_o);
    err   = lsu_rsp_err_o;
    rdata = lsu_rdata_o;
    check_eq({name, "_err"}, exp_err, err);
  endtask

  task automatic random_lsu_traffic();
    logic        we;
    mem_size_e   sz;
    int unsigned off;
    logic [31:0] wdata;
    logic [31:0] rdata;
    for (int i = 0; i < N_LSU; i++)
    begin
      we    = 1'($urandom_range(1));
      sz    = mem_size_e'($urandom_range(2));
      off   = $urandom_range(WIN_BYTES - 1);
      // natural alignment for the size
      off   = off - (off % (1 << int'(sz)));
      wdata = $urandom;
      issue_lsu("lsu_random", we, sz, SRAM_BASE + off, wdata, 1'b0, rdata);
      if (we)
      begin
        apply_store(off, sz, wdata);
      end
      else
      begin
        check_eq("lsu_load", expected_load(off, sz), rdata);
      end
      // idle gaps let fetch win the bus
      repeat ($urandom_range(3)) @(posedge clk);
    end
  endtask

  task automatic random_fetch_traffic();
    int unsigned off;
    logic [31:0] exp;
    for (int i = 0; i < N_FETCH; i++)
    begin
      off = $urandom_range(WIN_BYTES / 4 - 1) * 4;
      @(posedge clk);
      fetch_req_valid_i <= 1'b1;
      fetch_addr_i      <= SRAM_BASE + off;
      fetch_issued++;
      do
        @(negedge clk);
      while (!fetch_req_ready_o);
      // memory as it stands at acceptance
      exp = expected_load(off, SZ_WORD);
      @(posedge clk);
      fetch_req_valid_i <= 1'b0;
      do
        @(negedge clk);
      while (!fetch_rsp_valid_o);
      check_eq("fetch_err", 1'b0, fetch_rsp_err_o);
      check_eq("fetch_word", exp, fetch_rdata_o);
      repeat ($urandom_range(2)) @(posedge clk);
    end
  endtask

  // response counting, never more responses than requests
  always @(negedge clk)
  begin
    if (!rst)
    begin
      // ready only for a valid requester, lsu ahead of fetch
      check_eq("lsu_ready_idle", 1'b0, lsu_req_ready_o && !lsu_req_valid_i);
      check_eq("fetch_ready_idle", 1'b0, fetch_req_ready_o && !fetch_req_valid_i);
      check_eq("fetch_ready_prio", 1'b0, fetch_req_ready_o && lsu_req_valid_i);
      if (lsu_rsp_valid_o)
      begin
        lsu_rsp_cnt++;
      end
      if (fetch_rsp_valid_o)
      begin
        fetch_rsp_cnt++;
      end
      if (lsu_rsp_cnt > lsu_issued)
      begin
        check_eq("lsu_extra_rsp", lsu_issued, lsu_rsp_cnt);
      end
      if (fetch_rsp_cnt > fetch_issued)
      begin
        check_eq("fetch_extra_rsp", fetch_issued, fetch_rsp_cnt);
      end
    end
  end

  initial
  begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles", MAX_CYCLES);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin : main
    int unsigned off;
    int unsigned kind;
    logic        we;
    mem_size_e   sz;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] cmp_lo;
    logic [31:0] cmp_hi;
    logic [31:0] t0;
    fetch_req_valid_i = 1'b0;
    fetch_addr_i      = '0;
    lsu_req_valid_i   = 1'b0;
    lsu_addr_i        = '0;
    lsu_we_i          = 1'b0;
    lsu_size_i        = SZ_WORD;
    lsu_wdata_i       = '0;
    lsu_issued        = 0;
    fetch_issued      = 0;
    lsu_rsp_cnt       = 0;
    fetch_rsp_cnt     = 0;
    void'($urandom(SEED));
    do
      @(negedge clk);
    while (rst !== 1'b0);

    // quiet outputs before any request
    repeat (8)
    begin
      @(negedge clk);
      check_eq("idle_lsu_rsp", 1'b0, lsu_rsp_valid_o);
      check_eq("idle_fetch_rsp", 1'b0, fetch_rsp_valid_o);
      check_eq("idle_irq", 1'b0, timer_irq_o);
    end

    // give every modelled byte a known value
    for (int i = 0; i < N_FILL; i++)
    begin
      wdata = $urandom;
      issue_lsu("fill", 1'b1, SZ_WORD, SRAM_BASE + 4 * i, wdata, 1'b0, rdata);
      apply_store(4 * i, SZ_WORD, wdata);
    end

    fork
      random_lsu_traffic();
      random_fetch_traffic();
    join

    // misaligned and unmapped, then the word must be unchanged
    for (int i = 0; i < N_ERR; i++)
    begin
      kind = $urandom_range(2);
      off  = $urandom_range(WIN_BYTES / 4 - 1) * 4;
      case (kind)
        0:
        begin
          sz   = SZ_HALF;
          addr = SRAM_BASE + off + 1 + 2 * $urandom_range(1);
        end
        1:
        begin
          sz   = SZ_WORD;
          addr = SRAM_BASE + off + 1 + $urandom_range(2);
        end
        default:
        begin
          sz   = SZ_WORD;
          // past the end would alias onto off if it reached the sram
          addr = ($urandom_range(1) != 0) ? SRAM_BASE + SRAM_BYTES + off : 32'h1000_0000 + off;
        end
      endcase
      we = 1'($urandom_range(1));
      issue_lsu("bad_access", we, sz, addr, $urandom, 1'b1, rdata);
      check_eq("bad_access_data", 32'h0, rdata);
      issue_lsu("after_bad", 1'b0, SZ_WORD, SRAM_BASE + off, 32'h0, 1'b0, rdata);
      check_eq("after_bad_word", expected_load(off, SZ_WORD), rdata);
    end

    // mtimecmp readback, top bit set keeps the irq quiet
    cmp_lo = $urandom;
    cmp_hi = $urandom | 32'h8000_0000;
    issue_lsu("cmp_wr_lo", 1'b1, SZ_WORD, CMP_ADDR, cmp_lo, 1'b0, rdata);
    issue_lsu("cmp_wr_hi", 1'b1, SZ_WORD, CMP_ADDR + 4, cmp_hi, 1'b0, rdata);
    issue_lsu("cmp_rd_lo", 1'b0, SZ_WORD, CMP_ADDR, 32'h0, 1'b0, rdata);
    check_eq("cmp_lo", cmp_lo, rdata);
    issue_lsu("cmp_rd_hi", 1'b0, SZ_WORD, CMP_ADDR + 4, 32'h0, 1'b0, rdata);
    check_eq("cmp_hi", cmp_hi, rdata);

    // mtime counts up
    issue_lsu("time_rd0", 1'b0, SZ_WORD, TIME_ADDR, 32'h0, 1'b0, t0);
    issue_lsu("time_rd1", 1'b0, SZ_WORD, TIME_ADDR, 32'h0, 1'b0, rdata);
    check_eq("mtime_increase", 1'b1, rdata > t0);

    // compare of zero fires at once
    issue_lsu("cmp_zero_lo", 1'b1, SZ_WORD, CMP_ADDR, 32'h0, 1'b0, rdata);
    issue_lsu("cmp_zero_hi", 1'b1, SZ_WORD, CMP_ADDR + 4, 32'h0, 1'b0, rdata);
    issue_lsu("irq_on_rd", 1'b0, SZ_WORD, TIME_ADDR, 32'h0, 1'b0, rdata);
    check_eq("irq_high", 1'b1, timer_irq_o);
    issue_lsu("cmp_ones_lo", 1'b1, SZ_WORD, CMP_ADDR, 32'hFFFF_FFFF, 1'b0, rdata);
    issue_lsu("cmp_ones_hi", 1'b1, SZ_WORD, CMP_ADDR + 4, 32'hFFFF_FFFF, 1'b0, rdata);
    issue_lsu("irq_off_rd", 1'b0, SZ_WORD, TIME_ADDR, 32'h0, 1'b0, rdata);
    check_eq("irq_low", 1'b0, timer_irq_o);

    // mtime is read only
    issue_lsu("time_wr", 1'b1, SZ_WORD, TIME_ADDR, $urandom, 1'b1, rdata);
    check_eq("time_wr_data", 32'h0, rdata);

    // let the monitor count the last strobe
    @(posedge clk);
    check_eq("lsu_rsp_count", lsu_issued, lsu_rsp_cnt);
    check_eq("fetch_rsp_count", fetch_issued, fetch_rsp_cnt);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held for 16 rising edges
  initial
  begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule
